//--- bench/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

`default_nettype none

// reference arithmetic for the bench, kept in wide integers so nothing wraps

// nine pixel by weight products of one window, summed
function automatic longint dot3x3(conv_data_pkg::window_t px, conv_data_pkg::kernel_t kw);
        longint s;
        s = 0;
        for (int t = 0; t < 9; t++) begin
                s = s + longint'(px[t]) * longint'(kw[t]);
        end
        return s;
endfunction

// first and single codes begin a fresh total
function automatic bit starts_total(conv_batch_pkg::batch_t code);
        return (code == conv_batch_pkg::BATCH_FIRST) || (code == conv_batch_pkg::BATCH_SINGLE);
endfunction

// last and single codes produce a result
function automatic bit ends_total(conv_batch_pkg::batch_t code);
        return (code == conv_batch_pkg::BATCH_LAST) || (code == conv_batch_pkg::BATCH_SINGLE);
endfunction

function automatic longint add_batch(longint total, longint sum, conv_batch_pkg::batch_t code);
        if (starts_total(code)) begin
                return sum;
        end
        return total + sum;
endfunction

// clip to a signed 24-bit result
function automatic longint clip_out(longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< 23) - 1;
        lo = -(longint'(1) <<< 23);
        if (v > hi) begin
                return hi;
        end
        if (v < lo) begin
                return lo;
        end
        return v;
endfunction

`default_nettype wire

`endif

//--- bench/conv_tb.sv
`timescale 1ns/10ps
`include "conv_model.svh"
`default_nettype none

module conv_tb
        import conv_data_pkg::*;
        import conv_batch_pkg::*;
();

localparam int IN_CH          = 4;
localparam int OUT_CH         = 4;
localparam int SEED_INIT      = 60911;
localparam int RST_CYCLES     = 8;
localparam int TIMEOUT_MARGIN = 20;
localparam int N_TESTS        = 5;

// data modes
localparam int D_RAND   = 0;
localparam int D_MAXPOS = 1;
localparam int D_MAXNEG = 2;
localparam int D_ZERO   = 3;

// weight and bias modes
localparam int W_RAND   = 0;
localparam int W_SAT_HI = 1;
localparam int W_SAT_LO = 2;

typedef conv_out_t [OUT_CH-1:0] out_vec_t;

typedef struct {
        batch_t code;
        int     dmode;
        int     wmode;
        bit     gap;
        int     test;
} step_t;

logic                             sclk;
logic                             rst;
window_t [IN_CH-1:0]              data_in;
logic                             data_in_vld;
batch_t                           batch_type;
kernel_t [OUT_CH-1:0][IN_CH-1:0]  weight;
bias_t   [OUT_CH-1:0]             bias;
out_vec_t                         conv_out;
logic                             conv_out_vld;

int       seed;
int       cyc;
int       cyc_limit;
int       cur_test;
step_t    steps [$];
int       exp_stamp [$];
out_vec_t exp_val [$];
int       exp_test [$];
longint   acc_ref [OUT_CH];
out_vec_t last_out;
int       checks [1:N_TESTS];
int       errs [1:N_TESTS];
string    test_name [1:N_TESTS];

conv_top dut_i (
        .sclk         (sclk),
        .rst          (rst),
        .data_in      (data_in),
        .data_in_vld  (data_in_vld),
        .batch_type   (batch_type),
        .weight       (weight),
        .bias         (bias),
        .conv_out     (conv_out),
        .conv_out_vld (conv_out_vld)
);

initial begin
        sclk = 1'b0;
        forever #20 sclk = ~sclk;
end

always @(posedge sclk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
                $display("run timed out after %0d cycles", cyc);
                $display("TESTS FAILED");
                $finish;
        end
end

//======================================================================
// output checker
//======================================================================
always @(negedge sclk) begin : check_outputs
        out_vec_t want;
        int       stamp;
        int       t;
        if (!rst) begin
                if (exp_stamp.size() != 0 && exp_stamp[0] < cyc) begin
                        $display("result due at cycle %0d never arrived (test %0d)",
                                 exp_stamp[0], exp_test[0]);
                        errs[exp_test[0]]++;
                        stamp = exp_stamp.pop_front();
                        t = exp_test.pop_front();
                        want = exp_val.pop_front();
                end
                if (conv_out_vld) begin
                        if (exp_stamp.size() == 0) begin
                                $display("conv_out_vld high at cycle %0d with no result due",
                                         cyc);
                                errs[cur_test]++;
                        end else begin
                                stamp = exp_stamp.pop_front();
                                t = exp_test.pop_front();
                                want = exp_val.pop_front();
                                checks[t]++;
                                assert (cyc == stamp) else begin
                                        $display("FAIL %0t: conv_out_vld at cycle %0d, due %0d",
                                                 $time, cyc, stamp);
                                        errs[t]++;
                                end
                                for (int o = 0; o < OUT_CH; o++) begin
                                        checks[t]++;
                                        assert (conv_out[o] == want[o]) else begin
                                                $display("FAIL %0t: channel %0d got %0d, want %0d",
                                                         $time, o, conv_out[o], want[o]);
                                                errs[t]++;
                                        end
                                end
                                last_out = want;
                        end
                end else begin
                        // result holds between closing batches
                        for (int o = 0; o < OUT_CH; o++) begin
                                assert (conv_out[o] == last_out[o]) else begin
                                        $display("FAIL %0t: channel %0d moved to %0d without vld",
                                                 $time, o, conv_out[o]);
                                        errs[cur_test]++;
                                end
                        end
                end
        end
end

//======================================================================
// stimulus helpers
//======================================================================
task automatic add_step(batch_t code, int dmode, int wmode, bit gap, int test);
        step_t s;
        s.code = code;
        s.dmode = dmode;
        s.wmode = wmode;
        s.gap = gap;
        s.test = test;
        steps.push_back(s);
endtask

function automatic bit new_segment(int i);
        if (i == 0) begin
                return 1'b1;
        end
        return (steps[i].test != steps[i-1].test) || (steps[i].wmode != steps[i-1].wmode);
endfunction

task automatic fill_window(int dmode);
        for (int c = 0; c < IN_CH; c++) begin
                for (int t = 0; t < WIN_TAPS; t++) begin
                        case (dmode)
                                D_RAND:   data_in[c][t] = pixel_t'($random(seed));
                                D_MAXPOS: data_in[c][t] = pixel_t'(127);
                                D_MAXNEG: data_in[c][t] = pixel_t'(-128);
                                default:  data_in[c][t] = '0;
                        endcase
                end
        end
endtask

// weights -128 everywhere for the clipping cases
task automatic load_weights(int wmode);
        for (int o = 0; o < OUT_CH; o++) begin
                for (int c = 0; c < IN_CH; c++) begin
                        for (int t = 0; t < WIN_TAPS; t++) begin
                                weight[o][c][t] = (wmode == W_RAND) ?
                                        weight_t'($random(seed)) : weight_t'(-128);
                        end
                end
                case (wmode)
                        W_RAND:   bias[o] = bias_t'($random(seed) >>> 11);
                        W_SAT_HI: bias[o] = bias_t'(32'sh7000_0000);
                        default:  bias[o] = bias_t'(-32'sh7000_0000);
                endcase
        end
endtask

task automatic apply_step(input step_t s);
        longint   ch;
        out_vec_t want;
        fill_window(s.dmode);
        batch_type = s.code;
        data_in_vld = 1'b1;
        for (int o = 0; o < OUT_CH; o++) begin
                ch = 0;
                for (int c = 0; c < IN_CH; c++) begin
                        ch = ch + dot3x3(data_in[c], weight[o][c]);
                end
                acc_ref[o] = add_batch(acc_ref[o], ch, s.code);
                want[o] = conv_out_t'(clip_out(acc_ref[o] + longint'(bias[o])));
        end
        if (ends_total(s.code)) begin
                exp_stamp.push_back(cyc + 4);
                exp_val.push_back(want);
                exp_test.push_back(s.test);
        end
        @(negedge sclk);
        if (s.gap) begin
                data_in_vld = 1'b0;
                @(negedge sclk);
        end
endtask

task automatic drain();
        data_in_vld = 1'b0;
        while (exp_stamp.size() != 0) begin
                @(negedge sclk);
        end
        repeat (2) @(negedge sclk);
endtask

task automatic check_reset_state();
        checks[1]++;
        assert (conv_out_vld == 1'b0) else begin
                $display("FAIL %0t: conv_out_vld high in reset state", $time);
                errs[1]++;
        end
        for (int o = 0; o < OUT_CH; o++) begin
                checks[1]++;
                assert (conv_out[o] == '0) else begin
                        $display("FAIL %0t: channel %0d is %0d in reset state",
                                 $time, o, conv_out[o]);
                        errs[1]++;
                end
        end
endtask

task automatic report_test(int t);
        $display("test %0d %s: %0d checks, %0d errors", t, test_name[t], checks[t], errs[t]);
endtask

//======================================================================
// main sequence
//======================================================================
initial begin : run
        int n_seg;
        int total_checks;
        int total_errs;
        seed = SEED_INIT;
        rst = 1'b1;
        data_in = '0;
        data_in_vld = 1'b0;
        batch_type = BATCH_FIRST;
        weight = '0;
        bias = '0;
        last_out = '0;
        cur_test = 1;
        for (int t = 1; t <= N_TESTS; t++) begin
                checks[t] = 0;
                errs[t] = 0;
        end
        for (int o = 0; o < OUT_CH; o++) begin
                acc_ref[o] = 0;
        end
        test_name[1] = "reset state";
        test_name[2] = "single batch";
        test_name[3] = "multi batch";
        test_name[4] = "saturation";
        test_name[5] = "back to back";

        // code, data, weights, gap, test
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b1, 2);
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b0, 2);
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b1, 2);
        add_step(BATCH_SINGLE, D_ZERO,   W_RAND,   1'b1, 2);
        add_step(BATCH_FIRST,  D_RAND,   W_RAND,   1'b1, 3);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b0, 3);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b1, 3);
        add_step(BATCH_LAST,   D_RAND,   W_RAND,   1'b1, 3);
        add_step(BATCH_FIRST,  D_RAND,   W_RAND,   1'b0, 3);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b0, 3);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b0, 3);
        add_step(BATCH_LAST,   D_RAND,   W_RAND,   1'b1, 3);
        add_step(BATCH_SINGLE, D_MAXNEG, W_SAT_HI, 1'b0, 4);
        add_step(BATCH_FIRST,  D_MAXNEG, W_SAT_HI, 1'b0, 4);
        add_step(BATCH_LAST,   D_MAXNEG, W_SAT_HI, 1'b1, 4);
        add_step(BATCH_SINGLE, D_MAXPOS, W_SAT_LO, 1'b0, 4);
        add_step(BATCH_SINGLE, D_MAXNEG, W_SAT_LO, 1'b1, 4);
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_FIRST,  D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_LAST,   D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b0, 5);
        // second first drops the open total
        add_step(BATCH_FIRST,  D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_FIRST,  D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_MID,    D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_LAST,   D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b0, 5);
        add_step(BATCH_SINGLE, D_RAND,   W_RAND,   1'b1, 5);

        n_seg = 0;
        for (int i = 0; i < steps.size(); i++) begin
                if (new_segment(i)) begin
                        n_seg++;
                end
        end
        // two cycles per step at most, plus a drain per weight set
        cyc_limit = RST_CYCLES + 3 + 2 * steps.size() + n_seg * (FEED_LAT + 4)
                    + TIMEOUT_MARGIN;

        repeat (RST_CYCLES) begin
                @(negedge sclk);
                check_reset_state();
        end
        rst = 1'b0;
        repeat (3) begin
                @(negedge sclk);
                check_reset_state();
        end
        report_test(1);

        for (int i = 0; i < steps.size(); i++) begin
                if (new_segment(i)) begin
                        if (i != 0) begin
                                drain();
                                if (steps[i].test != steps[i-1].test) begin
                                        report_test(steps[i-1].test);
                                end
                        end
                        cur_test = steps[i].test;
                        load_weights(steps[i].wmode);
                end
                apply_step(steps[i]);
        end
        drain();
        report_test(steps[steps.size()-1].test);

        total_checks = 0;
        total_errs = 0;
        for (int t = 1; t <= N_TESTS; t++) begin
                total_checks += checks[t];
                total_errs += errs[t];
        end
        $display("%0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
                $display("TESTS PASSED");
        end else begin
                $display("TESTS FAILED");
        end
        $finish;
end

endmodule

`default_nettype wire

//--- logic/batch_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module batch_accumulator
        import conv_data_pkg::*;
        import conv_batch_pkg::*;
(
        input  logic      sclk,
        input  logic      rst,
        input  chan_sum_t sum,
        input  logic      sum_vld,
        input  batch_t    batch,
        input  bias_t     bias,
        output conv_out_t conv_out,
        output logic      conv_out_vld
);

acc_t      total;
acc_t      total_next;
acc_ext_t  biased;
conv_out_t sat;
logic      open_q;
logic      closing;

assign closing = sum_vld && batch_closes(batch);

//======================================================================
// next total, bias and clip
//======================================================================
always_comb begin
        if (batch_opens(batch)) begin
                total_next = acc_t'(sum);
        end else begin
                total_next = total + acc_t'(sum);
        end
        // one extra bit so the bias add cannot wrap
        biased = acc_ext_t'(total_next) + acc_ext_t'(bias);
        if (biased > acc_ext_t'(OUT_MAX)) begin
                sat = conv_out_t'(OUT_MAX);
        end else if (biased < acc_ext_t'(OUT_MIN)) begin
                sat = conv_out_t'(OUT_MIN);
        end else begin
                sat = conv_out_t'(biased);
        end
end

always_ff @(posedge sclk) begin
        if (rst) begin
                total        <= '0;
                open_q       <= 1'b0;
                conv_out     <= '0;
                conv_out_vld <= 1'b0;
        end else begin
                conv_out_vld <= closing;
                if (sum_vld) begin
                        total  <= total_next;
                        open_q <= !batch_closes(batch);
                end
                if (closing) begin
                        conv_out <= sat;
                end
        end
end

//======================================================================
// checks
//======================================================================
// mid or last with nothing open
a_open_seq: assert property (@(posedge sclk) disable iff (rst)
        sum_vld && !batch_opens(batch) |-> open_q)
        else $error("batch code %0d with no open accumulation", batch);

endmodule

`default_nettype wire

//--- logic/conv_batch_pkg.sv
`default_nettype none

package conv_batch_pkg;

        typedef enum logic [1:0] {
                BATCH_FIRST  = 2'd0,
                BATCH_MID    = 2'd1,
                BATCH_LAST   = 2'd2,
                BATCH_SINGLE = 2'd3
        } batch_t;

        // starts a fresh total
        function automatic logic batch_opens(batch_t code);
                return (code == BATCH_FIRST) || (code == BATCH_SINGLE);
        endfunction

        // adds bias and emits a result
        function automatic logic batch_closes(batch_t code);
                return (code == BATCH_LAST) || (code == BATCH_SINGLE);
        endfunction

endpackage

`default_nettype wire

//--- logic/conv_data_pkg.sv
`default_nettype none

package conv_data_pkg;

        //======================================================================
        // widths and element types
        //======================================================================
        localparam int WIN_TAPS = 9;
        localparam int ACC_W    = 32;

        typedef logic signed [7:0]  pixel_t;
        typedef logic signed [7:0]  weight_t;

        // raster order, index 0 is top left
        typedef pixel_t  [WIN_TAPS-1:0] window_t;
        typedef weight_t [WIN_TAPS-1:0] kernel_t;

        typedef logic signed [15:0] prod_t;
        typedef logic signed [19:0] dot_t;
        typedef logic signed [23:0] chan_sum_t;

        typedef logic signed [ACC_W-1:0] acc_t;
        typedef logic signed [ACC_W:0]   acc_ext_t;
        typedef logic signed [31:0]      bias_t;
        typedef logic signed [23:0]      conv_out_t;

        //======================================================================
        // pipeline latencies
        //======================================================================
        localparam int DOT_LAT  = 2;
        localparam int SUM_LAT  = 1;
        localparam int FEED_LAT = DOT_LAT + SUM_LAT;

        // clip range of conv_out_t
        localparam int OUT_MAX = 2 ** ($bits(conv_out_t) - 1) - 1;
        localparam int OUT_MIN = -(2 ** ($bits(conv_out_t) - 1));

endpackage

`default_nettype wire

//--- logic/conv_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_top
        import conv_data_pkg::*;
        import conv_batch_pkg::*;
#(
        parameter int IN_CH  = 4,
        parameter int OUT_CH = 4
) (
        input  logic                              sclk,
        input  logic                              rst,
        input  window_t   [IN_CH-1:0]             data_in,
        input  logic                              data_in_vld,
        input  batch_t                            batch_type,
        input  kernel_t   [OUT_CH-1:0][IN_CH-1:0] weight,
        input  bias_t     [OUT_CH-1:0]            bias,
        output conv_out_t [OUT_CH-1:0]            conv_out,
        output logic                              conv_out_vld
);

chan_sum_t sum [OUT_CH];
logic      sum_vld;
batch_t    sum_batch;

//======================================================================
// control aligned with the channel sums
//======================================================================
delay_line #(
        .DEPTH     (FEED_LAT),
        .payload_t (logic)
) u_vld_dly (
        .sclk (sclk),
        .rst  (rst),
        .d    (data_in_vld),
        .q    (sum_vld)
);

delay_line #(
        .DEPTH     (FEED_LAT),
        .payload_t (batch_t)
) u_batch_dly (
        .sclk (sclk),
        .rst  (rst),
        .d    (batch_type),
        .q    (sum_batch)
);

//======================================================================
// output channels
//======================================================================
for (genvar o = 0; o < OUT_CH; o++) begin : g_out
        out_channel #(
                .IN_CH (IN_CH)
        ) u_chan (
                .sclk    (sclk),
                .rst     (rst),
                .data_in (data_in),
                .weight  (weight[o]),
                .sum     (sum[o])
        );

        // all accumulators pulse together, channel 0 speaks for them
        if (o == 0) begin : g_lead
                batch_accumulator u_acc (
                        .sclk         (sclk),
                        .rst          (rst),
                        .sum          (sum[o]),
                        .sum_vld      (sum_vld),
                        .batch        (sum_batch),
                        .bias         (bias[o]),
                        .conv_out     (conv_out[o]),
                        .conv_out_vld (conv_out_vld)
                );
        end else begin : g_follow
                batch_accumulator u_acc (
                        .sclk         (sclk),
                        .rst          (rst),
                        .sum          (sum[o]),
                        .sum_vld      (sum_vld),
                        .batch        (sum_batch),
                        .bias         (bias[o]),
                        .conv_out     (conv_out[o]),
                        .conv_out_vld ()
                );
        end
end

endmodule

`default_nettype wire

//--- logic/delay_line.sv
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
        parameter int  DEPTH     = 1,
        parameter type payload_t = logic
) (
        input  logic     sclk,
        input  logic     rst,
        input  payload_t d,
        output payload_t q
);

payload_t stage [DEPTH];

always_ff @(posedge sclk) begin
        if (rst) begin
                for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= payload_t'(0);
                end
        end else begin
                stage[0] <= d;
                for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                end
        end
end

assign q = stage[DEPTH-1];

// a zero-length line would have no register to read
a_depth_min: assert property (@(posedge sclk) DEPTH >= 1)
        else $error("delay_line depth %0d below one", DEPTH);

endmodule

`default_nettype wire

//--- logic/out_channel.sv
`timescale 1ns/10ps
`default_nettype none

module out_channel
        import conv_data_pkg::*;
#(
        parameter int IN_CH = 4
) (
        input  logic                  sclk,
        input  logic                  rst,
        input  window_t [IN_CH-1:0]   data_in,
        input  kernel_t [IN_CH-1:0]   weight,
        output chan_sum_t             sum
);

dot_t      dot [IN_CH];
chan_sum_t sum_next;

//======================================================================
// one dot product per input channel
//======================================================================
for (genvar c = 0; c < IN_CH; c++) begin : g_in
        window_dot u_dot (
                .sclk   (sclk),
                .rst    (rst),
                .pixels (data_in[c]),
                .taps   (weight[c]),
                .dot    (dot[c])
        );
end

//======================================================================
// cross-channel sum
//======================================================================
always_comb begin
        sum_next = '0;
        for (int c = 0; c < IN_CH; c++) begin
                sum_next = sum_next + chan_sum_t'(dot[c]);
        end
end

always_ff @(posedge sclk) begin
        if (rst) begin
                sum <= '0;
        end else begin
                sum <= sum_next;
        end
end

endmodule

`default_nettype wire

//--- logic/window_dot.sv
`timescale 1ns/10ps
`default_nettype none

module window_dot
        import conv_data_pkg::*;
(
        input  logic    sclk,
        input  logic    rst,
        input  window_t pixels,
        input  kernel_t taps,
        output dot_t    dot
);

prod_t prod_q [WIN_TAPS];
dot_t  tap_sum;

//======================================================================
// stage 1: nine signed products
//======================================================================
always_ff @(posedge sclk) begin
        if (rst) begin
                for (int i = 0; i < WIN_TAPS; i++) begin
                        prod_q[i] <= '0;
                end
        end else begin
                for (int i = 0; i < WIN_TAPS; i++) begin
                        prod_q[i] <= prod_t'(pixels[i]) * prod_t'(taps[i]);
                end
        end
end

//======================================================================
// stage 2: tap sum
//======================================================================
// nine full-scale products still fit in 20 bits
always_comb begin
        tap_sum = '0;
        for (int i = 0; i < WIN_TAPS; i++) begin
                tap_sum = tap_sum + dot_t'(prod_q[i]);
        end
end

always_ff @(posedge sclk) begin
        if (rst) begin
                dot <= '0;
        end else begin
                dot <= tap_sum;
        end
end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the convolution testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module conv_tb -f sim.f -o conv_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/conv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
        exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
        echo "no result line found in $LOG"
        exit 1
fi

exit 0

//--- sim.f
+incdir+bench
logic/conv_data_pkg.sv
logic/conv_batch_pkg.sv
logic/window_dot.sv
logic/delay_line.sv
logic/out_channel.sv
logic/batch_accumulator.sv
logic/conv_top.sv
bench/conv_tb.sv
